// ==== hw/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  wb_sel_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function field of SPECIAL
    localparam funct_t FN_SLL   = 6'h00;
    localparam funct_t FN_SRL   = 6'h02;
    localparam funct_t FN_SRA   = 6'h03;
    localparam funct_t FN_JR    = 6'h08;
    localparam funct_t FN_JALR  = 6'h09;
    localparam funct_t FN_MFHI  = 6'h10;
    localparam funct_t FN_MFLO  = 6'h12;
    localparam funct_t FN_MULT  = 6'h18;
    localparam funct_t FN_MULTU = 6'h19;
    localparam funct_t FN_ADDU  = 6'h21;
    localparam funct_t FN_SUBU  = 6'h23;
    localparam funct_t FN_AND   = 6'h24;
    localparam funct_t FN_OR    = 6'h25;
    localparam funct_t FN_XOR   = 6'h26;
    localparam funct_t FN_NOR   = 6'h27;
    localparam funct_t FN_SLT   = 6'h2a;
    localparam funct_t FN_SLTU  = 6'h2b;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_NOR  = 4'd5;
    localparam alu_op_t ALU_SLT  = 4'd6;
    localparam alu_op_t ALU_SLTU = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_LUI  = 4'd11;

    localparam wb_sel_t WB_ALU  = 3'd0;
    localparam wb_sel_t WB_MEM  = 3'd1;
    localparam wb_sel_t WB_LINK = 3'd2;
    localparam wb_sel_t WB_HI   = 3'd3;
    localparam wb_sel_t WB_LO   = 3'd4;

    localparam word_t    RESET_VECTOR = 32'hbfc0_0000;
    localparam reg_idx_t LINK_REG     = 5'd31;

endpackage

`default_nettype wire

// ==== hw/decode_if.sv ====
`default_nettype none

interface decode_if import mips_pkg::*; ();

    // execute controls
    alu_op_t     alu_op;
    logic        use_imm;
    word_t       imm;
    logic [4:0]  shamt;

    // register writeback
    logic        reg_write;
    reg_idx_t    write_index;
    wb_sel_t     wb_sel;

    logic        mem_read;
    logic        mem_write;

    // flow control
    logic        branch_eq;
    logic        branch_ne;
    logic        jump_imm;
    logic [25:0] jump_index;
    logic        jump_reg;

    logic        hilo_write;
    logic        mult_signed;

    modport decoder (
        output alu_op, use_imm, imm, shamt, reg_write, write_index, wb_sel,
               mem_read, mem_write, branch_eq, branch_ne, jump_imm, jump_index,
               jump_reg, hilo_write, mult_signed
    );

    modport execute (input alu_op, use_imm, imm, shamt);

    modport fetch (input branch_eq, branch_ne, jump_imm, jump_index, jump_reg, imm);

    modport writeback (
        input hilo_write, mult_signed, reg_write, write_index, wb_sel, mem_read, mem_write
    );

endinterface

`default_nettype wire

// ==== hw/instr_decode.sv ====
`default_nettype none

module instr_decode import mips_pkg::*; (
    input  word_t     instr,
    output reg_idx_t  rs,
    output reg_idx_t  rt,
    decode_if.decoder ctrl
);

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rd;
    word_t    sign_imm;
    word_t    zero_imm;
    word_t    upper_imm;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    assign sign_imm  = {{16{instr[15]}}, instr[15:0]};
    assign zero_imm  = {16'h0000, instr[15:0]};
    assign upper_imm = {instr[15:0], 16'h0000};

    // raw fields, only meaningful for the instructions that use them
    assign ctrl.shamt      = instr[10:6];
    assign ctrl.jump_index = instr[25:0];

    always_comb begin
        // anything unrecognised falls through as a no-op
        ctrl.alu_op      = ALU_ADD;
        ctrl.use_imm     = 1'b0;
        ctrl.imm         = sign_imm;
        ctrl.reg_write   = 1'b0;
        ctrl.write_index = rt;
        ctrl.wb_sel      = WB_ALU;
        ctrl.mem_read    = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.branch_eq   = 1'b0;
        ctrl.branch_ne   = 1'b0;
        ctrl.jump_imm    = 1'b0;
        ctrl.jump_reg    = 1'b0;
        ctrl.hilo_write  = 1'b0;
        ctrl.mult_signed = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                ctrl.write_index = rd;
                ctrl.reg_write   = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                    FN_SRA:  ctrl.alu_op = ALU_SRA;
                    FN_MFHI: ctrl.wb_sel = WB_HI;
                    FN_MFLO: ctrl.wb_sel = WB_LO;
                    FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.jump_reg  = 1'b1;
                    end
                    // link goes to rd, no delay slot so pc + 4
                    FN_JALR: begin
                        ctrl.jump_reg = 1'b1;
                        ctrl.wb_sel   = WB_LINK;
                    end
                    FN_MULT: begin
                        ctrl.reg_write   = 1'b0;
                        ctrl.hilo_write  = 1'b1;
                        ctrl.mult_signed = 1'b1;
                    end
                    FN_MULTU: begin
                        ctrl.reg_write  = 1'b0;
                        ctrl.hilo_write = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_J: ctrl.jump_imm = 1'b1;
            OP_JAL: begin
                ctrl.jump_imm    = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.write_index = LINK_REG;
                ctrl.wb_sel      = WB_LINK;
            end
            OP_BEQ: ctrl.branch_eq = 1'b1;
            OP_BNE: ctrl.branch_ne = 1'b1;
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (opcode)
                    OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    // sltiu still sign-extends, compare is unsigned
                    OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                    OP_ANDI: begin
                        ctrl.alu_op = ALU_AND;
                        ctrl.imm    = zero_imm;
                    end
                    OP_ORI: begin
                        ctrl.alu_op = ALU_OR;
                        ctrl.imm    = zero_imm;
                    end
                    OP_XORI: begin
                        ctrl.alu_op = ALU_XOR;
                        ctrl.imm    = zero_imm;
                    end
                    OP_LUI: begin
                        ctrl.alu_op = ALU_LUI;
                        ctrl.imm    = upper_imm;
                    end
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_MEM;
                ctrl.mem_read  = 1'b1;
            end
            OP_SW: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: ctrl.reg_write = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`default_nettype none

module regfile import mips_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t read_index_a,
    input  reg_idx_t read_index_b,
    output word_t    read_data_a,
    output word_t    read_data_b,
    input  logic     write_enable,
    input  reg_idx_t write_index,
    input  word_t    write_data,
    output word_t    register_v0
);

    // register 0 has no storage
    word_t regs [1:31];

    assign read_data_a = (read_index_a == '0) ? '0 : regs[read_index_a];
    assign read_data_b = (read_index_b == '0) ? '0 : regs[read_index_b];
    assign register_v0 = regs[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_index != '0) begin
            regs[write_index] <= write_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

module alu import mips_pkg::*; (
    input  word_t     op_a,
    input  word_t     op_b,
    decode_if.execute ctrl,
    output word_t     result
);

    word_t operand_b;

    // immediate replaces rt for I-type and load/store
    assign operand_b = ctrl.use_imm ? ctrl.imm : op_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: result = op_a + operand_b;
            ALU_SUB: result = op_a - operand_b;
            ALU_AND: result = op_a & operand_b;
            ALU_OR:  result = op_a | operand_b;
            ALU_XOR: result = op_a ^ operand_b;
            ALU_NOR: result = ~(op_a | operand_b);
            ALU_SLT: begin
                result = {31'd0, $signed(op_a) < $signed(operand_b)};
            end
            ALU_SLTU: begin
                result = {31'd0, op_a < operand_b};
            end
            // shifts act on rt by the shamt field
            ALU_SLL: result = operand_b << ctrl.shamt;
            ALU_SRL: result = operand_b >> ctrl.shamt;
            ALU_SRA: result = $signed(operand_b) >>> ctrl.shamt;
            // upper half already placed by the decoder
            ALU_LUI: result = operand_b;
            default: result = op_a + operand_b;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/hilo_unit.sv ====
`default_nettype none

module hilo_unit import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        write_enable,
    decode_if.writeback ctrl,
    input  word_t       op_a,
    input  word_t       op_b,
    output word_t       hi,
    output word_t       lo
);

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] product;

    // one extra bit makes a single signed multiply cover both mult and multu
    assign a_ext   = {ctrl.mult_signed & op_a[31], op_a};
    assign b_ext   = {ctrl.mult_signed & op_b[31], op_b};
    assign product = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (write_enable) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
`default_nettype none

module pc_unit import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    clk_enable,
    decode_if.fetch ctrl,
    input  word_t   rs_data,
    input  word_t   rt_data,
    output word_t   pc,
    output word_t   pc_plus4,
    output logic    active
);

    logic  taken;
    word_t branch_target;
    word_t jump_target;
    word_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    assign taken = (ctrl.branch_eq && rs_data == rt_data) ||
                   (ctrl.branch_ne && rs_data != rt_data);

    // word offset relative to the following instruction
    assign branch_target = pc_plus4 + {ctrl.imm[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], ctrl.jump_index, 2'b00};

    always_comb begin
        if (taken) begin
            next_pc = branch_target;
        end else if (ctrl.jump_imm) begin
            next_pc = jump_target;
        end else if (ctrl.jump_reg) begin
            next_pc = rs_data;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // halts for good once a jump to address 0 commits
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_VECTOR;
            active <= 1'b1;
        end else if (clk_enable && active) begin
            pc     <= next_pc;
            active <= (next_pc != '0);
        end
    end

endmodule

`default_nettype wire

// ==== hw/mips_cpu_harvard.sv ====
`default_nettype none

module mips_cpu_harvard import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output logic  active,
    output word_t register_v0,

    input  logic  clk_enable,

    output word_t instr_address,
    input  word_t instr_readdata,

    output word_t data_address,
    output logic  data_write,
    output logic  data_read,
    output word_t data_writedata,
    input  word_t data_readdata
);

    logic     commit;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_result;
    word_t    hi;
    word_t    lo;
    word_t    pc_plus4;
    word_t    write_data;

    decode_if dec ();

    // every architectural write waits for this
    assign commit = clk_enable && active;

    assign data_address   = alu_result;
    assign data_writedata = rt_data;
    assign data_read      = dec.mem_read;
    assign data_write     = dec.mem_write && commit;

    always_comb begin
        case (dec.wb_sel)
            WB_MEM:  write_data = data_readdata;
            WB_LINK: write_data = pc_plus4;
            WB_HI:   write_data = hi;
            WB_LO:   write_data = lo;
            default: write_data = alu_result;
        endcase
    end

    instr_decode instr_decode_i (
        .instr (instr_readdata),
        .rs    (rs),
        .rt    (rt),
        .ctrl  (dec.decoder)
    );

    regfile regfile_i (
        .clk          (clk),
        .reset        (reset),
        .read_index_a (rs),
        .read_index_b (rt),
        .read_data_a  (rs_data),
        .read_data_b  (rt_data),
        .write_enable (dec.reg_write && commit),
        .write_index  (dec.write_index),
        .write_data   (write_data),
        .register_v0  (register_v0)
    );

    alu alu_i (
        .op_a   (rs_data),
        .op_b   (rt_data),
        .ctrl   (dec.execute),
        .result (alu_result)
    );

    hilo_unit hilo_unit_i (
        .clk          (clk),
        .reset        (reset),
        .write_enable (dec.hilo_write && commit),
        .ctrl         (dec.writeback),
        .op_a         (rs_data),
        .op_b         (rt_data),
        .hi           (hi),
        .lo           (lo)
    );

    pc_unit pc_unit_i (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .ctrl       (dec.fetch),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .pc         (instr_address),
        .pc_plus4   (pc_plus4),
        .active     (active)
    );

endmodule

`default_nettype wire

// ==== tb/tb_mips_cpu_harvard.sv ====
`default_nettype none

module tb_mips_cpu_harvard import mips_pkg::*; ();

    localparam int PROG_WORDS  = 64;
    localparam int CYCLE_LIMIT = PROG_WORDS * 8 + 40;

    logic  clk;
    logic  reset;
    logic  clk_enable;
    logic  active;
    word_t register_v0;
    word_t instr_address;
    word_t instr_readdata;
    word_t data_address;
    logic  data_write;
    logic  data_read;
    word_t data_writedata;
    word_t data_readdata;

    int    seed;
    word_t prog [PROG_WORDS];
    logic  landable [PROG_WORDS];
    logic  jump_seq [PROG_WORDS];
    word_t dmem [256];

    // instruction-set model state
    word_t model_pc;
    word_t model_regs [32];
    word_t model_hi;
    word_t model_lo;
    word_t model_mem [256];
    logic  model_active;

    // previous negedge sample for the stall check
    logic  hold_last;
    word_t last_addr;
    word_t last_v0;
    int    cycles;
    int    halted_cycles;

    funct_t  alu_fns [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                              FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    opcode_t imm_ops [7]  = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                              OP_XORI, OP_LUI};

    mips_cpu_harvard mips_cpu_harvard_i (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    always #50 clk = ~clk;

    function automatic int rand_below(int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic reg_idx_t pick_dest();
        // register 2 is what register_v0 shows
        return (rand_below(3) == 0) ? reg_idx_t'(2) : reg_idx_t'(rand_below(32));
    endfunction

    function automatic word_t encode_r(reg_idx_t s, reg_idx_t t, reg_idx_t d,
                                       logic [4:0] sa, funct_t fn);
        return {OP_SPECIAL, s, t, d, sa, fn};
    endfunction

    function automatic word_t encode_i(opcode_t op, reg_idx_t s, reg_idx_t t,
                                       logic [15:0] imm);
        return {op, s, t, imm};
    endfunction

    function automatic word_t word_addr(int index);
        return RESET_VECTOR + word_t'(index * 4);
    endfunction

    // any landable word after the given one
    // word 63 always qualifies
    function automatic int forward_target(int from);
        int t;
        t = from + 1 + rand_below(PROG_WORDS - 1 - from);
        while (!landable[t]) begin
            t++;
        end
        return t;
    endfunction

    function automatic word_t fill_word(int i);
        logic [7:0] b;
        b = 8'(i);
        return {b, ~b, b ^ 8'h5a, 8'hc3};
    endfunction

    function automatic word_t fetch_word(word_t addr);
        word_t offset;
        offset = addr - RESET_VECTOR;
        if (offset < word_t'(PROG_WORDS * 4)) begin
            return prog[offset[7:2]];
        end else begin
            return 32'h0;
        end
    endfunction

    function automatic word_t random_instr(int i);
        reg_idx_t    s;
        reg_idx_t    t;
        reg_idx_t    d;
        logic [15:0] offset;
        word_t       w;
        s = reg_idx_t'(rand_below(32));
        t = reg_idx_t'(rand_below(32));
        d = pick_dest();
        offset = 16'(rand_below(256) * 4);
        case (rand_below(8))
            0, 1: w = encode_r(s, t, d, 5'(rand_below(32)), alu_fns[rand_below(11)]);
            2, 3: w = encode_i(imm_ops[rand_below(7)], s, d, 16'(rand_below(65536)));
            4: begin
                case (rand_below(4))
                    0: w = encode_r(s, t, 5'd0, 5'd0, FN_MULT);
                    1: w = encode_r(s, t, 5'd0, 5'd0, FN_MULTU);
                    2: w = encode_r(5'd0, 5'd0, d, 5'd0, FN_MFHI);
                    default: w = encode_r(5'd0, 5'd0, d, 5'd0, FN_MFLO);
                endcase
            end
            5: w = rand_below(2) ? encode_i(OP_LW, 5'd0, d, offset) :
                                   encode_i(OP_SW, 5'd0, t, offset);
            6: w = encode_i(rand_below(2) ? OP_BEQ : OP_BNE, s, t,
                            16'(forward_target(i) - i - 1));
            default: begin
                w = word_addr(forward_target(i));
                w = {rand_below(2) ? OP_J : OP_JAL, w[27:2]};
            end
        endcase
        return w;
    endfunction

    task automatic build_program();
        int       i;
        reg_idx_t s;
        word_t    addr;
        for (i = 0; i < PROG_WORDS; i++) begin
            landable[i] = 1'b1;
            jump_seq[i] = 1'b0;
        end
        // nothing may branch into the tail of a lui/ori/jr group
        for (i = 0; i < PROG_WORDS - 3; i++) begin
            if (landable[i] && rand_below(10) == 0) begin
                jump_seq[i]     = 1'b1;
                landable[i + 1] = 1'b0;
                landable[i + 2] = 1'b0;
            end
        end
        i = 0;
        while (i < PROG_WORDS - 1) begin
            if (jump_seq[i]) begin
                s = reg_idx_t'(1 + rand_below(31));
                addr = word_addr(forward_target(i + 2));
                prog[i]     = encode_i(OP_LUI, 5'd0, s, addr[31:16]);
                prog[i + 1] = encode_i(OP_ORI, s, s, addr[15:0]);
                prog[i + 2] = rand_below(2) ? encode_r(s, 5'd0, 5'd0, 5'd0, FN_JR) :
                                              encode_r(s, 5'd0, pick_dest(), 5'd0, FN_JALR);
                i = i + 3;
            end else begin
                prog[i] = random_instr(i);
                i++;
            end
        end
        prog[PROG_WORDS - 1] = encode_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR);
    endtask

    task automatic reset_model();
        model_pc     = RESET_VECTOR;
        model_active = 1'b1;
        model_hi     = '0;
        model_lo     = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
    endtask

    task automatic step_model();
        word_t       ins;
        word_t       a;
        word_t       b;
        word_t       imm_s;
        word_t       imm_z;
        word_t       addr;
        word_t       next_pc;
        word_t       res;
        reg_idx_t    dest;
        logic        wr;
        logic [63:0] prod;
        ins     = fetch_word(model_pc);
        a       = model_regs[ins[25:21]];
        b       = model_regs[ins[20:16]];
        imm_s   = {{16{ins[15]}}, ins[15:0]};
        imm_z   = {16'h0000, ins[15:0]};
        addr    = a + imm_s;
        next_pc = model_pc + 32'd4;
        res     = '0;
        wr      = 1'b1;
        dest    = ins[20:16];
        case (ins[31:26])
            OP_SPECIAL: begin
                dest = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << ins[10:6];
                    FN_SRL:  res = b >> ins[10:6];
                    FN_SRA:  res = $signed(b) >>> ins[10:6];
                    FN_MFHI: res = model_hi;
                    FN_MFLO: res = model_lo;
                    FN_JALR: begin
                        res     = model_pc + 32'd4;
                        next_pc = a;
                    end
                    FN_JR: begin
                        wr      = 1'b0;
                        next_pc = a;
                    end
                    FN_MULT, FN_MULTU: begin
                        wr = 1'b0;
                        if (ins[5:0] == FN_MULT) begin
                            prod = $signed(a) * $signed(b);
                        end else begin
                            prod = {32'd0, a} * {32'd0, b};
                        end
                        model_hi = prod[63:32];
                        model_lo = prod[31:0];
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_J, OP_JAL: begin
                wr      = (ins[31:26] == OP_JAL);
                dest    = LINK_REG;
                res     = model_pc + 32'd4;
                next_pc = {next_pc[31:28], ins[25:0], 2'b00};
            end
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                if ((a == b) == (ins[31:26] == OP_BEQ)) begin
                    next_pc = model_pc + 32'd4 + (imm_s << 2);
                end
            end
            OP_ADDIU: res = a + imm_s;
            OP_SLTI:  res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < imm_s) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & imm_z;
            OP_ORI:   res = a | imm_z;
            OP_XORI:  res = a ^ imm_z;
            OP_LUI:   res = {ins[15:0], 16'h0000};
            OP_LW:    res = model_mem[addr[9:2]];
            OP_SW: begin
                wr = 1'b0;
                model_mem[addr[9:2]] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != '0) begin
            model_regs[dest] = res;
        end
        model_pc     = next_pc;
        model_active = (next_pc != '0);
    endtask

    task automatic check_equal(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, actual,
                     expected);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_cycle();
        word_t ins;
        word_t addr;
        logic  store_expected;
        logic  load_expected;
        check_equal(instr_address, model_pc, "instr_address");
        check_equal(register_v0, model_regs[2], "register_v0");
        check_equal({31'd0, active}, {31'd0, model_active}, "active");
        ins = fetch_word(model_pc);
        addr = model_regs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]};
        store_expected = clk_enable && model_active && ins[31:26] == OP_SW;
        load_expected  = (ins[31:26] == OP_LW);
        check_equal({31'd0, data_write}, {31'd0, store_expected}, "data_write");
        check_equal({31'd0, data_read}, {31'd0, load_expected}, "data_read");
        if (store_expected) begin
            check_equal(data_address, addr, "data_address");
            check_equal(data_writedata, model_regs[ins[20:16]], "data_writedata");
        end
        // a stalled cycle must leave the core untouched
        if (hold_last) begin
            check_equal(instr_address, last_addr, "instr_address during stall");
            check_equal(register_v0, last_v0, "register_v0 during stall");
        end
        hold_last = !clk_enable;
        last_addr = instr_address;
        last_v0   = register_v0;
    endtask

    assign instr_readdata = fetch_word(instr_address);
    assign data_readdata  = dmem[data_address[9:2]];

    always @(posedge clk) begin
        if (data_write) begin
            dmem[data_address[9:2]] <= data_writedata;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else if (clk_enable && model_active) begin
            step_model();
        end
    end

    // enable three cycles in four
    always @(posedge clk) begin
        #10;
        clk_enable = (rand_below(4) != 0);
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        clk_enable = 1'b0;
        hold_last  = 1'b0;
        seed       = 4300;
        reset_model();
        build_program();
        for (int i = 0; i < 256; i++) begin
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        check_equal(instr_address, RESET_VECTOR, "instr_address after reset");
        check_equal({31'd0, active}, 32'd1, "active after reset");
        check_equal(register_v0, 32'd0, "register_v0 after reset");
        cycles        = 0;
        halted_cycles = 0;
        // keep watching for a while after the halt
        while (halted_cycles < 8) begin
            check_cycle();
            if (!model_active) begin
                halted_cycles++;
            end
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: the core never halted within %0d cycles", CYCLE_LIMIT);
                $display("Verification failed");
                $fatal(1, "timeout");
            end
            @(negedge clk);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_cpu_harvard.f ====
hw/mips_pkg.sv
hw/decode_if.sv
hw/instr_decode.sv
hw/regfile.sv
hw/alu.sv
hw/hilo_unit.sv
hw/pc_unit.sv
hw/mips_cpu_harvard.sv
tb/tb_mips_cpu_harvard.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_mips_cpu_harvard \
    -f mips_cpu_harvard.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
else
    echo "no pass message in sim.log"
    exit 1
fi
